//--- verilog/npu_pkg.sv
`default_nettype none

package npu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////////////////////////

    localparam int LANES = 8;                       // int8 lanes per line

    typedef logic signed [7:0] lane_t;
    typedef logic [LANES-1:0][7:0] line_t;          // Lane 0 in the low byte
    typedef logic signed [31:0] acc_t;              // Holds 256 lines of 8 products

    //////////////////////////////////////////////////////////////////////
    // Instruction word
    //////////////////////////////////////////////////////////////////////

    localparam int LINE_ADDR_W = 8;
    localparam int LEN_W       = 8;                 // Run length field, minus one
    localparam int SHIFT_W     = 5;

    typedef enum logic [1:0] {
        OP_END = 2'd0,
        OP_DOT = 2'd1
    } opcode_e;

    // opcode sits in the top two bits
    typedef struct packed {
        opcode_e                opcode;
        logic [LINE_ADDR_W-1:0] act_base;
        logic [LINE_ADDR_W-1:0] wgt_base;
        logic [LEN_W-1:0]       len_m1;
        logic [SHIFT_W-1:0]     q_shift;
        logic                   relu;
    } inst_t;

endpackage

`default_nettype wire

//--- verilog/host_wr_if.sv
`default_nettype none

// Host side write strobe into one buffer
interface host_wr_if #(
    parameter int  ADDR_W = 8,
    parameter type T      = logic
) ();

    logic              en;
    logic              we;       // Write only with en high too
    logic [ADDR_W-1:0] addr;
    T                  wdata;

    modport master (
        output en, we, addr, wdata
    );

    modport slave (
        input en, we, addr, wdata
    );

endinterface

`default_nettype wire

//--- verilog/job_if.sv
`default_nettype none

// One DOT job, controller to readers and engine
interface job_if
    import npu_pkg::*;
();

    logic                   start;      // Single cycle, fields valid with it
    logic [LINE_ADDR_W-1:0] act_base;
    logic [LINE_ADDR_W-1:0] wgt_base;
    logic [LEN_W-1:0]       len_m1;
    logic [SHIFT_W-1:0]     q_shift;
    logic                   relu;
    logic                   done;       // Back from the engine

    modport master (
        output start, act_base, wgt_base, len_m1, q_shift, relu,
        input  done
    );

    modport slave (
        input  start, act_base, wgt_base, len_m1, q_shift, relu,
        output done
    );

endinterface

`default_nettype wire

//--- verilog/buffer_ram.sv
`default_nettype none

module buffer_ram #(
    parameter int  ADDR_W = 8,
    parameter type T      = logic
) (
    input  wire logic              i_clk,
    host_wr_if.slave               i_host,
    input  wire logic              i_rd_en,
    input  wire logic [ADDR_W-1:0] i_raddr,
    output T                       o_rdata,
    output logic                   o_rdata_vld
);

    localparam int DEPTH = 1 << ADDR_W;

    T mem [0:DEPTH-1];

    // Host port
    always_ff @(posedge i_clk) begin
        if (i_host.en && i_host.we) begin
            mem[i_host.addr] <= i_host.wdata;
        end
    end

    // Internal read port, one cycle latency
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rdata <= mem[i_raddr];        // Holds until the next read
        end
    end

    always_ff @(posedge i_clk) begin
        o_rdata_vld <= i_rd_en;
    end

endmodule

`default_nettype wire

//--- verilog/operand_reader.sv
`default_nettype none

module operand_reader
    import npu_pkg::*;
#(
    parameter int  ADDR_W = 8,
    parameter type T      = line_t
) (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    host_wr_if.slave               i_host,
    input  wire logic              i_start,
    input  wire logic [ADDR_W-1:0] i_base,
    input  wire logic [LEN_W-1:0]  i_len_m1,
    output T                       o_line,
    output logic                   o_valid,
    output logic                   o_last
);

    logic              busy;        // One read per cycle while high
    logic [ADDR_W-1:0] rd_addr;
    logic [LEN_W-1:0]  run_cnt;     // Reads left after this one
    logic              last_q;

    //////////////////////////////////////////////////////////////////////
    // Address generator
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy    <= 1'b0;
            rd_addr <= '0;
            run_cnt <= '0;
            last_q  <= 1'b0;
        end else begin
            if (i_start) begin
                busy    <= 1'b1;
                rd_addr <= i_base;
                run_cnt <= i_len_m1;
            end else if (busy) begin
                rd_addr <= rd_addr + 1'b1;          // Wraps at the buffer end
                run_cnt <= run_cnt - 1'b1;
                if (run_cnt == '0) begin
                    busy <= 1'b0;
                end
            end
            last_q <= busy && (run_cnt == '0);      // Lines up with read latency
        end
    end

    buffer_ram #(
        .ADDR_W (ADDR_W),
        .T      (T)
    ) u_buf (
        .i_clk       (i_clk),
        .i_host      (i_host),
        .i_rd_en     (busy),
        .i_raddr     (rd_addr),
        .o_rdata     (o_line),
        .o_rdata_vld (o_valid)
    );

    assign o_last = last_q;

endmodule

`default_nettype wire

//--- verilog/inst_ctrl.sv
`default_nettype none

module inst_ctrl
    import npu_pkg::*;
#(
    parameter int INST_ADDR_W = 6
) (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_start_npu,
    input  wire logic i_stop_npu,
    host_wr_if.slave  i_host,
    job_if.master     o_job,
    output logic      o_npu_idle,
    output logic      o_internal_stop
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,        // Two cycles, read then wait
        S_ISSUE,
        S_WAIT_DONE
    } state_e;

    state_e                 state;
    logic [INST_ADDR_W-1:0] pc;
    logic                   stop_req;
    logic                   rd_en;
    logic                   rd_pend;
    inst_t                  inst;
    logic                   inst_vld;
    logic                   stop_now;
    logic                   is_dot;

    buffer_ram #(
        .ADDR_W (INST_ADDR_W),
        .T      (inst_t)
    ) u_inst_buf (
        .i_clk       (i_clk),
        .i_host      (i_host),
        .i_rd_en     (rd_en),
        .i_raddr     (pc),
        .o_rdata     (inst),
        .o_rdata_vld (inst_vld)
    );

    assign rd_en    = (state == S_FETCH) && !rd_pend;
    assign stop_now = stop_req || i_stop_npu;
    assign is_dot   = (inst.opcode == OP_DOT);

    //////////////////////////////////////////////////////////////////////
    // Decode, straight from the buffer output register
    //////////////////////////////////////////////////////////////////////

    assign o_job.start    = (state == S_ISSUE) && is_dot && !stop_now;
    assign o_job.act_base = inst.act_base;
    assign o_job.wgt_base = inst.wgt_base;
    assign o_job.len_m1   = inst.len_m1;
    assign o_job.q_shift  = inst.q_shift;
    assign o_job.relu     = inst.relu;

    assign o_npu_idle      = (state == S_IDLE);
    assign o_internal_stop = (state == S_ISSUE) && !is_dot && !stop_now;  // END only

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= S_IDLE;
            pc       <= '0;
            stop_req <= 1'b0;
            rd_pend  <= 1'b0;
        end else begin
            rd_pend <= rd_en;
            if (o_npu_idle) begin
                stop_req <= 1'b0;
            end else if (i_stop_npu) begin
                stop_req <= 1'b1;               // Honored at the next boundary
            end

            case (state)
                S_IDLE: begin
                    if (i_start_npu) begin
                        pc    <= '0;
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (inst_vld) begin
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (stop_now || !is_dot) begin
                        state <= S_IDLE;
                    end else begin
                        pc    <= pc + 1'b1;
                        state <= S_WAIT_DONE;
                    end
                end
                S_WAIT_DONE: begin
                    if (o_job.done) begin
                        state <= stop_now ? S_IDLE : S_FETCH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/dot_engine.sv
`default_nettype none

module dot_engine
    import npu_pkg::*;
(
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    job_if.slave       i_job,
    input  wire line_t i_act,
    input  wire logic  i_act_vld,
    input  wire logic  i_act_last,
    input  wire line_t i_wgt,
    output lane_t      o_result,
    output logic       o_result_vld
);

    localparam lane_t LANE_MAX = 127;
    localparam lane_t LANE_MIN = -128;

    acc_t               acc;
    acc_t               line_sum;
    acc_t               acc_next;
    acc_t               shifted;
    logic [SHIFT_W-1:0] q_shift;
    logic               relu;
    lane_t              sat_val;

    //////////////////////////////////////////////////////////////////////
    // Lane products
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        line_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            // Sign extend both lanes before the multiply
            line_sum += acc_t'(lane_t'(i_act[i])) * acc_t'(lane_t'(i_wgt[i]));
        end
    end

    // Weight stream is cycle aligned with the activations
    assign acc_next = acc + line_sum;

    //////////////////////////////////////////////////////////////////////
    // Requantize
    //////////////////////////////////////////////////////////////////////

    assign shifted = acc_next >>> q_shift;      // Arithmetic shift

    always_comb begin
        if (relu && shifted < 0) begin
            sat_val = '0;
        end else if (shifted > acc_t'(LANE_MAX)) begin
            sat_val = LANE_MAX;
        end else if (shifted < acc_t'(LANE_MIN)) begin
            sat_val = LANE_MIN;
        end else begin
            sat_val = lane_t'(shifted);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_job.start) begin
            acc     <= '0;
            q_shift <= i_job.q_shift;   // Job config held for the whole run
            relu    <= i_job.relu;
        end else if (i_act_vld) begin
            acc <= acc_next;
        end

        if (i_act_vld && i_act_last) begin
            o_result <= sat_val;        // Last line folded in here
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_result_vld <= 1'b0;
        end else begin
            o_result_vld <= i_act_vld && i_act_last;
        end
    end

    // Job ends with its result
    assign i_job.done = o_result_vld;

endmodule

`default_nettype wire

//--- verilog/npu_core.sv
`default_nettype none

module npu_core
    import npu_pkg::*;
#(
    parameter int INST_ADDR_W = 6,
    parameter int DATA_ADDR_W = 8
) (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,

    input  wire logic                   i_start_npu,
    input  wire logic                   i_stop_npu,
    output logic                        o_npu_idle,
    output logic                        o_internal_stop,

    output lane_t                       o_result,
    output logic                        o_result_vld,

    // Program load
    input  wire logic                   i_inst_bramctl_en,
    input  wire logic                   i_inst_bramctl_we,
    input  wire logic [INST_ADDR_W-1:0] i_inst_bramctl_addr,
    input  wire inst_t                  i_inst_bramctl_wdata,

    // Activation lines
    input  wire logic                   i_iob_bramctl_en,
    input  wire logic                   i_iob_bramctl_we,
    input  wire logic [DATA_ADDR_W-1:0] i_iob_bramctl_addr,
    input  wire line_t                  i_iob_bramctl_wdata,

    // Weight lines
    input  wire logic                   i_wb_bramctl_en,
    input  wire logic                   i_wb_bramctl_we,
    input  wire logic [DATA_ADDR_W-1:0] i_wb_bramctl_addr,
    input  wire line_t                  i_wb_bramctl_wdata
);

    if (DATA_ADDR_W > LINE_ADDR_W) begin : g_addr_w_check
        $error("DATA_ADDR_W is wider than the instruction base fields");
    end

    host_wr_if #(.ADDR_W(INST_ADDR_W), .T(inst_t)) inst_wr ();
    host_wr_if #(.ADDR_W(DATA_ADDR_W), .T(line_t)) iob_wr ();
    host_wr_if #(.ADDR_W(DATA_ADDR_W), .T(line_t)) wb_wr ();
    job_if                                         job ();

    line_t act_line;
    logic  act_valid;
    logic  act_last;
    line_t wgt_line;
    logic  wgt_valid;       // Mirrors act_valid, same start and length
    logic  wgt_last;

    assign inst_wr.en    = i_inst_bramctl_en;
    assign inst_wr.we    = i_inst_bramctl_we;
    assign inst_wr.addr  = i_inst_bramctl_addr;
    assign inst_wr.wdata = i_inst_bramctl_wdata;

    assign iob_wr.en     = i_iob_bramctl_en;
    assign iob_wr.we     = i_iob_bramctl_we;
    assign iob_wr.addr   = i_iob_bramctl_addr;
    assign iob_wr.wdata  = i_iob_bramctl_wdata;

    assign wb_wr.en      = i_wb_bramctl_en;
    assign wb_wr.we      = i_wb_bramctl_we;
    assign wb_wr.addr    = i_wb_bramctl_addr;
    assign wb_wr.wdata   = i_wb_bramctl_wdata;

    inst_ctrl #(
        .INST_ADDR_W (INST_ADDR_W)
    ) u_inst_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start_npu     (i_start_npu),
        .i_stop_npu      (i_stop_npu),
        .i_host          (inst_wr),
        .o_job           (job),
        .o_npu_idle      (o_npu_idle),
        .o_internal_stop (o_internal_stop)
    );

    operand_reader #(
        .ADDR_W (DATA_ADDR_W),
        .T      (line_t)
    ) u_act_reader (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_host   (iob_wr),
        .i_start  (job.start),
        .i_base   (job.act_base[DATA_ADDR_W-1:0]),
        .i_len_m1 (job.len_m1),
        .o_line   (act_line),
        .o_valid  (act_valid),
        .o_last   (act_last)
    );

    operand_reader #(
        .ADDR_W (DATA_ADDR_W),
        .T      (line_t)
    ) u_wgt_reader (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_host   (wb_wr),
        .i_start  (job.start),
        .i_base   (job.wgt_base[DATA_ADDR_W-1:0]),
        .i_len_m1 (job.len_m1),
        .o_line   (wgt_line),
        .o_valid  (wgt_valid),
        .o_last   (wgt_last)
    );

    dot_engine u_dot_engine (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_job        (job),
        .i_act        (act_line),
        .i_act_vld    (act_valid),
        .i_act_last   (act_last),
        .i_wgt        (wgt_line),
        .o_result     (o_result),
        .o_result_vld (o_result_vld)
    );

endmodule

`default_nettype wire

//--- sim/npu_core_chk.sv
`default_nettype none

module npu_core_chk (
    input wire logic i_clk,
    input wire logic i_rst_n,
    input wire logic i_npu_idle,
    input wire logic i_internal_stop,
    input wire logic i_result_vld,
    input wire logic i_act_valid,
    input wire logic i_wgt_valid,
    input wire logic i_act_last,
    input wire logic i_wgt_last
);
    timeunit 1ns;
    timeprecision 1ps;

    // Results only come out of a running program
    a_no_result_when_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_result_vld && i_npu_idle))
        else $error("Result strobe seen while the core is idle");

    a_stop_then_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_internal_stop |=> i_npu_idle)
        else $error("Internal stop was not followed by idle");

    // Both readers get the same start and length
    a_stream_valid_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_act_valid == i_wgt_valid)
        else $error("Activation and weight valid strobes differ");

    a_stream_last_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_act_last == i_wgt_last)
        else $error("Activation and weight last flags differ");

    a_result_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_result_vld |=> !i_result_vld)
        else $error("Result valid held high for two cycles");

endmodule

bind npu_core npu_core_chk u_npu_core_chk (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_npu_idle      (o_npu_idle),
    .i_internal_stop (o_internal_stop),
    .i_result_vld    (o_result_vld),
    .i_act_valid     (act_valid),
    .i_wgt_valid     (wgt_valid),
    .i_act_last      (act_last),
    .i_wgt_last      (wgt_last)
);

`default_nettype wire

//--- sim/npu_core_tb.sv
`default_nettype none

module npu_core_tb
    import npu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int INST_ADDR_W = 6;
    localparam int DATA_ADDR_W = 8;
    localparam int INST_DEPTH  = 1 << INST_ADDR_W;
    localparam int DATA_DEPTH  = 1 << DATA_ADDR_W;
    localparam int SEED        = 36164;
    localparam int N_RAND      = 12;
    localparam int N_CORNER    = 3;
    localparam int N_STOP      = 20;
    localparam int INST_CYCLES = 256 + 10;     // Longest DOT plus fetch and issue

    // Random program runs twice plus the END of every program
    localparam int TOTAL_INST  = 2 * (N_RAND + 1) + (N_CORNER + 1) + (N_STOP + 1);
    localparam int LOAD_CYCLES = 3 * DATA_DEPTH + 3 * INST_DEPTH + 20;
    localparam longint WATCHDOG_NS = longint'(TOTAL_INST * INST_CYCLES + LOAD_CYCLES) * 10;

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_start_npu;
    logic                   i_stop_npu;
    logic                   o_npu_idle;
    logic                   o_internal_stop;
    lane_t                  o_result;
    logic                   o_result_vld;
    logic                   i_inst_bramctl_en;
    logic                   i_inst_bramctl_we;
    logic [INST_ADDR_W-1:0] i_inst_bramctl_addr;
    inst_t                  i_inst_bramctl_wdata;
    logic                   i_iob_bramctl_en;
    logic                   i_iob_bramctl_we;
    logic [DATA_ADDR_W-1:0] i_iob_bramctl_addr;
    line_t                  i_iob_bramctl_wdata;
    logic                   i_wb_bramctl_en;
    logic                   i_wb_bramctl_we;
    logic [DATA_ADDR_W-1:0] i_wb_bramctl_addr;
    line_t                  i_wb_bramctl_wdata;

    // Mirrors of the three buffers
    inst_t model_inst [0:INST_DEPTH-1];
    line_t model_act  [0:DATA_DEPTH-1];
    line_t model_wgt  [0:DATA_DEPTH-1];

    int    exp_q [$];
    string test_name  = "startup";
    int    result_cnt = 0;
    int    stop_cnt   = 0;

    npu_core #(
        .INST_ADDR_W (INST_ADDR_W),
        .DATA_ADDR_W (DATA_ADDR_W)
    ) npu_core_inst (
        .i_clk                (i_clk),
        .i_rst_n              (i_rst_n),
        .i_start_npu          (i_start_npu),
        .i_stop_npu           (i_stop_npu),
        .o_npu_idle           (o_npu_idle),
        .o_internal_stop      (o_internal_stop),
        .o_result             (o_result),
        .o_result_vld         (o_result_vld),
        .i_inst_bramctl_en    (i_inst_bramctl_en),
        .i_inst_bramctl_we    (i_inst_bramctl_we),
        .i_inst_bramctl_addr  (i_inst_bramctl_addr),
        .i_inst_bramctl_wdata (i_inst_bramctl_wdata),
        .i_iob_bramctl_en     (i_iob_bramctl_en),
        .i_iob_bramctl_we     (i_iob_bramctl_we),
        .i_iob_bramctl_addr   (i_iob_bramctl_addr),
        .i_iob_bramctl_wdata  (i_iob_bramctl_wdata),
        .i_wb_bramctl_en      (i_wb_bramctl_en),
        .i_wb_bramctl_we      (i_wb_bramctl_we),
        .i_wb_bramctl_addr    (i_wb_bramctl_addr),
        .i_wb_bramctl_wdata   (i_wb_bramctl_wdata)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "Simulation stopped after the first error");
    endtask

    task automatic compare(input string what, input int expected, input int actual);
        if (expected != actual) begin
            report_failure($sformatf("Fail %s (%s): expected %0d, actual %0d",
                                     test_name, what, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Host writes and model
    //////////////////////////////////////////////////////////////////////

    task automatic write_inst(input logic [INST_ADDR_W-1:0] addr, input inst_t ins);
        @(negedge i_clk);
        i_inst_bramctl_en    = 1'b1;
        i_inst_bramctl_we    = 1'b1;
        i_inst_bramctl_addr  = addr;
        i_inst_bramctl_wdata = ins;
        model_inst[addr]     = ins;
    endtask

    task automatic write_act(input logic [DATA_ADDR_W-1:0] addr, input line_t line);
        @(negedge i_clk);
        i_iob_bramctl_en    = 1'b1;
        i_iob_bramctl_we    = 1'b1;
        i_iob_bramctl_addr  = addr;
        i_iob_bramctl_wdata = line;
        model_act[addr]     = line;
    endtask

    task automatic write_wgt(input logic [DATA_ADDR_W-1:0] addr, input line_t line);
        @(negedge i_clk);
        i_wb_bramctl_en    = 1'b1;
        i_wb_bramctl_we    = 1'b1;
        i_wb_bramctl_addr  = addr;
        i_wb_bramctl_wdata = line;
        model_wgt[addr]    = line;
    endtask

    task automatic release_host();
        @(negedge i_clk);
        i_inst_bramctl_en = 1'b0;
        i_inst_bramctl_we = 1'b0;
        i_iob_bramctl_en  = 1'b0;
        i_iob_bramctl_we  = 1'b0;
        i_wb_bramctl_en   = 1'b0;
        i_wb_bramctl_we   = 1'b0;
    endtask

    function automatic line_t random_line();
        line_t line;
        for (int k = 0; k < LANES; k++) begin
            line[k] = 8'($urandom);
        end
        return line;
    endfunction

    function automatic inst_t make_inst(input opcode_e op, input int act, input int wgt,
                                        input int len_m1, input int shift, input logic relu);
        inst_t ins;
        ins          = '0;
        ins.opcode   = op;
        ins.act_base = LINE_ADDR_W'(act);
        ins.wgt_base = LINE_ADDR_W'(wgt);
        ins.len_m1   = LEN_W'(len_m1);
        ins.q_shift  = SHIFT_W'(shift);
        ins.relu     = relu;
        return ins;
    endfunction

    function automatic inst_t random_dot();
        return make_inst(OP_DOT, $urandom_range(0, DATA_DEPTH - 1),
                         $urandom_range(0, DATA_DEPTH - 1), $urandom_range(0, 255),
                         $urandom_range(8, 16), 1'($urandom_range(0, 1)));
    endfunction

    // Dot over the run followed by shift, optional ReLU and int8 saturation
    function automatic int model_dot(input inst_t ins);
        logic [DATA_ADDR_W-1:0] a_addr;
        logic [DATA_ADDR_W-1:0] w_addr;
        longint                 acc;
        longint                 scaled;
        acc    = 0;
        a_addr = ins.act_base[DATA_ADDR_W-1:0];
        w_addr = ins.wgt_base[DATA_ADDR_W-1:0];
        for (int n = 0; n <= int'(ins.len_m1); n++) begin
            for (int k = 0; k < LANES; k++) begin
                acc += longint'($signed(model_act[a_addr][k]))
                     * longint'($signed(model_wgt[w_addr][k]));
            end
            a_addr++;           // Wraps like the buffer
            w_addr++;
        end
        scaled = acc >>> ins.q_shift;
        if (ins.relu && scaled < 0) begin
            return 0;
        end else if (scaled > 127) begin
            return 127;
        end else if (scaled < -128) begin
            return -128;
        end
        return int'(scaled);
    endfunction

    // Walk the mirrored program up to its END
    function automatic void build_expected();
        logic [INST_ADDR_W-1:0] pc;
        pc = '0;
        exp_q.delete();
        while (model_inst[pc].opcode == OP_DOT) begin
            exp_q.push_back(model_dot(model_inst[pc]));
            pc++;
        end
    endfunction

    task automatic load_random_program(input int n_dot);
        for (int i = 0; i < n_dot; i++) begin
            write_inst(INST_ADDR_W'(i), random_dot());
        end
        write_inst(INST_ADDR_W'(n_dot), make_inst(OP_END, 0, 0, 0, 0, 1'b0));
        release_host();
    endtask

    task automatic load_random_data(input bit with_weights);
        for (int i = 0; i < DATA_DEPTH; i++) begin
            write_act(DATA_ADDR_W'(i), random_line());
            if (with_weights) begin
                write_wgt(DATA_ADDR_W'(i), random_line());
            end
        end
        release_host();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////////////////////////

    task automatic wait_for_idle(input int limit);
        int cycles;
        cycles = 0;
        while (!o_npu_idle) begin
            @(negedge i_clk);
            cycles++;
            if (cycles > limit) begin
                report_failure($sformatf("Core did not return to idle within %0d cycles in %s",
                                         limit, test_name));
            end
        end
    endtask

    task automatic run_program(input int n_dot, input bit stop_early,
                               output int n_results, output int n_stops);
        int res_base;
        int stop_base;
        int cycles;
        res_base  = result_cnt;
        stop_base = stop_cnt;
        cycles    = 0;
        @(negedge i_clk);
        i_start_npu = 1'b1;
        @(negedge i_clk);
        i_start_npu = 1'b0;
        if (stop_early) begin
            while (result_cnt == res_base) begin
                @(negedge i_clk);
                cycles++;
                if (cycles > 2 * INST_CYCLES) begin
                    report_failure("No result arrived before the stop request was due");
                end
            end
            i_stop_npu = 1'b1;          // Right after the first result
            @(negedge i_clk);
            i_stop_npu = 1'b0;
        end
        wait_for_idle((n_dot + 1) * INST_CYCLES);
        n_results = result_cnt - res_base;
        n_stops   = stop_cnt - stop_base;
    endtask

    // Result and stop monitor
    always @(posedge i_clk) begin
        if (o_result_vld) begin
            if (exp_q.size() == 0) begin
                report_failure($sformatf("Unexpected result %0d during %s", o_result, test_name));
            end else begin
                compare("result", exp_q.pop_front(), int'(o_result));
            end
            result_cnt = result_cnt + 1;
        end
        if (o_internal_stop) begin
            stop_cnt = stop_cnt + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("Watchdog expired because the core hung before the tests finished");
    end

    initial begin
        int n_res;
        int n_stop;
        i_rst_n              = 1'b0;
        i_start_npu          = 1'b0;
        i_stop_npu           = 1'b0;
        i_inst_bramctl_en    = 1'b0;
        i_inst_bramctl_we    = 1'b0;
        i_inst_bramctl_addr  = '0;
        i_inst_bramctl_wdata = '0;
        i_iob_bramctl_en     = 1'b0;
        i_iob_bramctl_we     = 1'b0;
        i_iob_bramctl_addr   = '0;
        i_iob_bramctl_wdata  = '0;
        i_wb_bramctl_en      = 1'b0;
        i_wb_bramctl_we      = 1'b0;
        i_wb_bramctl_addr    = '0;
        i_wb_bramctl_wdata   = '0;
        void'($urandom(SEED));
        repeat (5) @(negedge i_clk);
        i_rst_n = 1'b1;

        test_name = "reset state";
        @(negedge i_clk);
        compare("idle", 1, int'(o_npu_idle));
        compare("result valid", 0, int'(o_result_vld));
        compare("internal stop", 0, int'(o_internal_stop));

        test_name = "random program";
        load_random_data(1'b1);
        load_random_program(N_RAND);
        build_expected();
        run_program(N_RAND, 1'b0, n_res, n_stop);
        compare("result count", N_RAND, n_res);
        compare("internal stop pulses", 1, n_stop);

        // Same program over fresh activations
        test_name = "back-to-back run";
        load_random_data(1'b0);
        build_expected();
        run_program(N_RAND, 1'b0, n_res, n_stop);
        compare("result count", N_RAND, n_res);
        compare("internal stop pulses", 1, n_stop);

        test_name = "saturation corners";
        for (int i = 0; i < 4; i++) begin
            write_act(DATA_ADDR_W'(i), {LANES{8'h7f}});
            write_act(DATA_ADDR_W'(i + 4), {LANES{8'h80}});
            write_wgt(DATA_ADDR_W'(i), {LANES{8'h7f}});
        end
        write_inst(0, make_inst(OP_DOT, 0, 0, 0, 0, 1'b0));
        write_inst(1, make_inst(OP_DOT, 4, 0, 0, 0, 1'b0));
        write_inst(2, make_inst(OP_DOT, 4, 0, 3, 0, 1'b1));    // Negative sum under ReLU
        write_inst(3, make_inst(OP_END, 0, 0, 0, 0, 1'b0));
        release_host();
        exp_q.delete();
        exp_q.push_back(127);
        exp_q.push_back(-128);
        exp_q.push_back(0);
        run_program(N_CORNER, 1'b0, n_res, n_stop);
        compare("result count", N_CORNER, n_res);
        compare("internal stop pulses", 1, n_stop);

        test_name = "stop mid-run";
        load_random_program(N_STOP);
        build_expected();
        run_program(N_STOP, 1'b1, n_res, n_stop);
        if (n_res == 0 || n_res >= N_STOP) begin
            report_failure($sformatf("Stop mid-run gave %0d results instead of a partial run",
                                     n_res));
        end
        compare("internal stop pulses", 0, n_stop);
        exp_q.delete();

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- npu_core.f
verilog/npu_pkg.sv
verilog/host_wr_if.sv
verilog/job_if.sv
verilog/buffer_ram.sv
verilog/operand_reader.sv
verilog/inst_ctrl.sv
verilog/dot_engine.sv
verilog/npu_core.sv
sim/npu_core_chk.sv
sim/npu_core_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := npu_core_tb
FILELIST  := npu_core.f
OBJ_DIR   := obj_dir
PASS_MSG  := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
